/* logic/bpu_macros.svh */
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// address and instruction width
`define XLEN 32

// bimodal direction table, indexed by pc[9:1]
`define BIMODAL_ENTRIES 512
`define BIMODAL_IDX_W   9

// direct-mapped btb, index pc[9:2], tag pc[31:10]
`define BTB_ENTRIES 256
`define BTB_IDX_W   8
`define BTB_TAG_W   22

// return address stack, pointer one bit wider to hold "full"
`define RAS_DEPTH 8
`define RAS_PTR_W 4

`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111

`define CTR_INIT 2'b01 // weakly not taken

`endif

/* logic/bpu_pkg.sv */
`include "bpu_macros.svh"

package bpu_pkg;

    typedef logic [`XLEN-1:0] addr_t;

    // conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    // jal layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // jalr layout
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        b_type_t b;
        j_type_t j;
        i_type_t i;
    } inst_u;

    // resolved control instruction from execute
    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t pc;
        addr_t target;
        inst_u inst;
    } upd_t;

    typedef struct packed {
        logic  valid;
        addr_t addr; // return address of the call
    } push_t;

    typedef struct packed {
        logic  is_ctrl;
        logic  taken;
        addr_t target;
    } pred_t;

endpackage

/* logic/bpu_ctrl.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_ctrl import bpu_pkg::*; (
    input  addr_t if_pc_i,
    input  inst_u if_inst_i,
    input  upd_t  upd_i,
    input  push_t push_i,
    input  logic  stall_i,
    input  logic  bm_taken_i,
    input  logic  btb_hit_i,
    input  addr_t btb_target_i,
    input  addr_t ras_top_i,
    input  logic  ras_empty_i,
    output push_t ras_push_o,
    output logic  ras_pop_o,
    output pred_t pred_o
);

    // jalr x0, 0(x1) or jalr x0, 0(x5)
    function automatic logic is_return(inst_u w);
        logic link_src;
        link_src = (w.i.rs1 == 5'd1) || (w.i.rs1 == 5'd5);
        return (w.i.opcode == `OPC_JALR) && (w.i.rd == 5'd0) && link_src &&
               (w.i.imm == 12'd0);
    endfunction

    logic  is_branch;
    logic  is_jal;
    logic  is_jalr;
    logic  is_ret;
    addr_t b_imm;
    addr_t j_imm;
    addr_t pc_plus4;

    // opcode sits in the same place in every view
    assign is_branch = (if_inst_i.b.opcode == `OPC_BRANCH);
    assign is_jal    = (if_inst_i.j.opcode == `OPC_JAL);
    assign is_jalr   = (if_inst_i.i.opcode == `OPC_JALR);
    assign is_ret    = is_return(if_inst_i);

    assign b_imm = {{19{if_inst_i.b.imm12}}, if_inst_i.b.imm12, if_inst_i.b.imm11,
                    if_inst_i.b.imm10_5, if_inst_i.b.imm4_1, 1'b0};
    assign j_imm = {{11{if_inst_i.j.imm20}}, if_inst_i.j.imm20, if_inst_i.j.imm19_12,
                    if_inst_i.j.imm11, if_inst_i.j.imm10_1, 1'b0};
    assign pc_plus4 = if_pc_i + addr_t'(4);

    always_comb begin
        pred_o.is_ctrl = is_branch || is_jal || is_jalr;
        pred_o.taken   = 1'b0;
        pred_o.target  = pc_plus4; // fall through by default
        if (is_ret) begin
            if (!ras_empty_i) begin
                pred_o.taken  = 1'b1;
                pred_o.target = ras_top_i;
            end
        end else if (is_jalr) begin
            if (btb_hit_i) begin // indirect target only known from the btb
                pred_o.taken  = 1'b1;
                pred_o.target = btb_target_i;
            end
        end else if (is_jal) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit_i ? btb_target_i : if_pc_i + j_imm;
        end else if (is_branch && bm_taken_i) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit_i ? btb_target_i : if_pc_i + b_imm;
        end
    end

    // stack moves only when the pipeline advances
    assign ras_push_o.valid = push_i.valid && !stall_i;
    assign ras_push_o.addr  = push_i.addr;
    assign ras_pop_o = upd_i.valid && upd_i.taken && is_return(upd_i.inst) && !stall_i;

endmodule

/* logic/bimodal_table.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bimodal_table import bpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t lookup_pc_i,
    input  upd_t  upd_i,
    output logic  taken_o
);

    logic [1:0] ctr_q [`BIMODAL_ENTRIES];

    logic [`BIMODAL_IDX_W-1:0] lookup_idx;
    logic [`BIMODAL_IDX_W-1:0] upd_idx;
    logic [1:0]                upd_ctr;

    // bit 0 ignored, compressed-aligned indexing
    assign lookup_idx = lookup_pc_i[`BIMODAL_IDX_W:1];
    assign upd_idx    = upd_i.pc[`BIMODAL_IDX_W:1];
    assign upd_ctr    = ctr_q[upd_idx];

    assign taken_o = ctr_q[lookup_idx][1]; // msb gives direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BIMODAL_ENTRIES; i++) begin
                ctr_q[i] <= `CTR_INIT;
            end
        end else if (upd_i.valid) begin
            if (upd_i.taken) begin
                if (upd_ctr != 2'b11) begin
                    ctr_q[upd_idx] <= upd_ctr + 2'd1;
                end
            end else begin
                if (upd_ctr != 2'b00) begin
                    ctr_q[upd_idx] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

/* logic/btb.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module btb import bpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t lookup_pc_i,
    input  upd_t  upd_i,
    output logic  hit_o,
    output addr_t target_o
);

    logic [`BTB_TAG_W-1:0] tag_q    [`BTB_ENTRIES];
    addr_t                 target_q [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0] valid_q;

    logic [`BTB_IDX_W-1:0] lookup_idx;
    logic [`BTB_TAG_W-1:0] lookup_tag;
    logic [`BTB_IDX_W-1:0] upd_idx;
    logic [`BTB_TAG_W-1:0] upd_tag;
    logic                  wr_en;

    assign lookup_idx = lookup_pc_i[`BTB_IDX_W+1:2];
    assign lookup_tag = lookup_pc_i[`XLEN-1:`XLEN-`BTB_TAG_W];
    assign upd_idx    = upd_i.pc[`BTB_IDX_W+1:2];
    assign upd_tag    = upd_i.pc[`XLEN-1:`XLEN-`BTB_TAG_W];
    assign wr_en      = upd_i.valid && upd_i.taken; // only taken ones allocate

    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd_i.target;
        end
    end

    // tags of never-written entries must stay masked by the valid bit
    a_hit_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(hit_o));

endmodule

/* logic/ras.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module ras import bpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  push_t push_i,
    input  logic  pop_i,
    output addr_t top_o,
    output logic  empty_o
);

    addr_t stack_q [`RAS_DEPTH];

    logic [`RAS_PTR_W-1:0] sp_q;   // next free slot
    logic [`RAS_PTR_W-1:0] sp_dec;
    logic [`RAS_PTR_W-1:0] sp_pop; // pointer after the pop
    logic [`RAS_PTR_W-1:0] sp_nxt;
    logic                  do_pop;
    logic                  do_push;

    assign empty_o = (sp_q == '0);
    assign sp_dec  = sp_q - 1'b1;
    assign top_o   = stack_q[sp_dec[`RAS_PTR_W-2:0]];

    // pop first, then push into the freed slot
    assign do_pop  = pop_i && !empty_o;
    assign sp_pop  = do_pop ? sp_dec : sp_q;
    assign do_push = push_i.valid && (sp_pop != `RAS_PTR_W'(`RAS_DEPTH)); // drop when full
    assign sp_nxt  = do_push ? sp_pop + 1'b1 : sp_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_pop[`RAS_PTR_W-2:0]] <= push_i.addr;
        end
    end

    a_sp_in_range: assert property (
        @(posedge clk) disable iff (rst) sp_q <= `RAS_PTR_W'(`RAS_DEPTH)
    );

endmodule

/* logic/bpu_top.sv */
`timescale 1ns/1ns

module bpu_top import bpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t if_pc_i,
    input  inst_u if_inst_i,
    input  upd_t  upd_i,
    input  push_t push_i,
    input  logic  stall_i,
    output pred_t pred_o
);

    logic  bm_taken;
    logic  btb_hit;
    addr_t btb_target;
    addr_t ras_top;
    logic  ras_empty;
    push_t ras_push;
    logic  ras_pop;

    bpu_ctrl u_ctrl (
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .upd_i        (upd_i),
        .push_i       (push_i),
        .stall_i      (stall_i),
        .bm_taken_i   (bm_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_top_i    (ras_top),
        .ras_empty_i  (ras_empty),
        .ras_push_o   (ras_push),
        .ras_pop_o    (ras_pop),
        .pred_o       (pred_o)
    );

    // both tables look up the fetch pc and learn from execute feedback
    bimodal_table u_bimodal (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .upd_i       (upd_i),
        .taken_o     (bm_taken)
    );

    btb u_btb (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .upd_i       (upd_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    ras u_ras (
        .clk     (clk),
        .rst     (rst),
        .push_i  (ras_push),
        .pop_i   (ras_pop),
        .top_o   (ras_top),
        .empty_o (ras_empty)
    );

endmodule

/* verilation/tb_bpu_top.sv */
`timescale 1ns/1ns

module tb_bpu_top import bpu_pkg::*; ();

    // one stimulus line of fetch, feedback, push, stall and expected prediction
    typedef struct packed {
        addr_t pc;
        inst_u inst;
        upd_t  upd;
        push_t push;
        logic  stall;
        pred_t exp;
    } vec_t;

    logic  clk;
    logic  rst;
    addr_t if_pc;
    inst_u if_inst;
    upd_t  upd;
    push_t push;
    logic  stall;
    pred_t pred;

    vec_t vecs[$];
    int   cycles = 0;
    int   cycle_limit = 0; // zero until the file is read

    bpu_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .if_pc_i   (if_pc),
        .if_inst_i (if_inst),
        .upd_i     (upd),
        .push_i    (push),
        .stall_i   (stall),
        .pred_o    (pred)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Test FAILED");
            $fatal(1, "run timed out after %0d cycles", cycles);
        end
    end

    task automatic load_vectors();
        int fd;
        int n;
        logic [31:0] pc, inst, uv, ut, upc, utgt, uinst;
        logic [31:0] pv, paddr, st, ec, et, etgt;
        logic [8*200-1:0] skip;
        vec_t v;
        fd = $fopen("verilation/bpu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Test FAILED");
            $fatal(1, "cannot open the stimulus file verilation/bpu_stimulus.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h\n",
                        pc, inst, uv, ut, upc, utgt, uinst, pv, paddr, st, ec, et, etgt);
            if (n == 13) begin
                v.pc          = pc;
                v.inst        = inst;
                v.upd.valid   = uv[0];
                v.upd.taken   = ut[0];
                v.upd.pc      = upc;
                v.upd.target  = utgt;
                v.upd.inst    = uinst;
                v.push.valid  = pv[0];
                v.push.addr   = paddr;
                v.stall       = st[0];
                v.exp.is_ctrl = ec[0];
                v.exp.taken   = et[0];
                v.exp.target  = etgt;
                vecs.push_back(v);
            end else if (n <= 0) begin
                void'($fgets(skip, fd)); // comment line or end of file
            end else begin
                $display("Test FAILED");
                $fatal(1, "stimulus line %0d has only %0d fields", vecs.size() + 1, n);
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("Test FAILED");
            $fatal(1, "the stimulus file holds no vectors");
        end
    endtask

    task automatic check_dir(string name, pred_t exp, pred_t act);
        if (act.is_ctrl !== exp.is_ctrl || act.taken !== exp.taken) begin
            $display("Error: %s direction expected is_ctrl=%b taken=%b actual is_ctrl=%b taken=%b",
                     name, exp.is_ctrl, exp.taken, act.is_ctrl, act.taken);
            $display("Test FAILED");
            $fatal(1, "prediction direction mismatch");
        end
    endtask

    task automatic check_target(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("Error: %s target expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "prediction target mismatch");
        end
    endtask

    initial begin
        rst     = 1'b1;
        if_pc   = '0;
        if_inst = '0;
        upd     = '0;
        push    = '0;
        stall   = 1'b0;
        load_vectors();
        cycle_limit = vecs.size() + 20;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 0; k < vecs.size(); k++) begin
            @(posedge clk);
            #1; // drive just after the edge
            if_pc   = vecs[k].pc;
            if_inst = vecs[k].inst;
            upd     = vecs[k].upd;
            push    = vecs[k].push;
            stall   = vecs[k].stall;
            #2; // one ns before the next edge
            check_dir($sformatf("vector %0d", k + 1), vecs[k].exp, pred);
            check_target($sformatf("vector %0d", k + 1), vecs[k].exp.target, pred.target);
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* bpu_top.f */
+incdir+logic
logic/bpu_pkg.sv
logic/bpu_ctrl.sv
logic/bimodal_table.sv
logic/btb.sv
logic/ras.sv
logic/bpu_top.sv
verilation/tb_bpu_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_bpu_top
FILELIST  := bpu_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verilation/bpu_stimulus.txt */
# fetch_pc fetch_inst upd_valid upd_taken upd_pc upd_target upd_inst push_valid push_addr
# stall exp_is_ctrl exp_taken exp_target (all hex, one line per cycle)
00000100 00000013 0 0 00000000 00000000 00000000 0 00000000 0 0 0 00000104
00001000 00000863 0 0 00000000 00000000 00000000 0 00000000 0 1 0 00001004
00001000 00000863 1 1 00001000 00001010 00000863 0 00000000 0 1 0 00001004
00001000 00000863 1 1 00001000 00001010 00000863 0 00000000 0 1 1 00001010
00001000 00000863 1 0 00001000 00001004 00000863 0 00000000 0 1 1 00001010
00001000 00000863 1 0 00001000 00001004 00000863 0 00000000 0 1 1 00001010
00001000 00000863 0 0 00000000 00000000 00000000 0 00000000 0 1 0 00001004
00001000 00000863 1 1 00001000 00001010 00000863 0 00000000 0 1 0 00001004
00001000 00000863 1 1 00001000 00001010 00000863 0 00000000 0 1 1 00001010
00001000 00000863 1 1 00001000 00001010 00000863 0 00000000 0 1 1 00001010
00001000 00000863 1 0 00001000 00001004 00000863 0 00000000 0 1 1 00001010
00001000 00000863 0 0 00000000 00000000 00000000 0 00000000 0 1 1 00001010
00002000 00000863 0 0 00000000 00000000 00000000 0 00000000 0 1 1 00002010
00003004 1000006f 1 1 00003004 00abcde0 1000006f 0 00000000 0 1 1 00003104
00003004 1000006f 0 0 00000000 00000000 00000000 0 00000000 0 1 1 00abcde0
00007004 1000006f 0 0 00000000 00000000 00000000 1 00000504 0 1 1 00007104
00000400 00000013 0 0 00000000 00000000 00000000 1 00000608 0 0 0 00000404
00000800 00008067 0 0 00000000 00000000 00000000 0 00000000 0 1 1 00000608
00000800 00008067 1 1 00000800 00000608 00008067 0 00000000 0 1 1 00000608
00000800 00008067 0 0 00000000 00000000 00000000 0 00000000 0 1 1 00000504
00000800 00008067 1 1 00000800 00000504 00008067 0 00000000 0 1 1 00000504
00000800 00008067 0 0 00000000 00000000 00000000 1 00000a00 1 1 0 00000804
00000800 00008067 0 0 00000000 00000000 00000000 1 00001100 0 1 0 00000804
00000400 00000013 0 0 00000000 00000000 00000000 1 00001200 0 0 0 00000404
00000400 00000013 0 0 00000000 00000000 00000000 1 00001300 0 0 0 00000404
00000400 00000013 0 0 00000000 00000000 00000000 1 00001400 0 0 0 00000404
00000400 00000013 0 0 00000000 00000000 00000000 1 00001500 0 0 0 00000404
00000400 00000013 0 0 00000000 00000000 00000000 1 00001600 0 0 0 00000404
00000400 00000013 0 0 00000000 00000000 00000000 1 00001700 0 0 0 00000404
00000400 00000013 0 0 00000000 00000000 00000000 1 00001800 0 0 0 00000404
00000400 00000013 0 0 00000000 00000000 00000000 1 00001900 0 0 0 00000404
00000800 00008067 1 1 00000800 00001800 00008067 1 00002a00 0 1 1 00001800
00000800 00008067 0 0 00000000 00000000 00000000 0 00000000 0 1 1 00002a00
